//--- uart_periph.f
+incdir+include
verilog/uart_pkg.sv
verilog/uart_cmd_decode.sv
verilog/uart_encoder.sv
verilog/uart_decoder.sv
verilog/uart_result.sv
verilog/uart_top.sv
test/uart_sva.sv
test/uart_tb.sv

//--- test/uart_tb.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_tb;
	import uart_pkg::*;

	// Bit periods in clocks for the two divisors used
	localparam int DEF_BIT  = 16;
	localparam int FAST_BIT = 8;
	// 8 default frames, then 93 fast bit periods over tests 2 to 6
	localparam int RUN_CYCLES     = 8 * 10 * DEF_BIT + 93 * FAST_BIT;
	localparam int TIMEOUT_CYCLES = RUN_CYCLES * 3 / 2;

	logic                      uart_clk;
	logic                      stop_bit;
	logic                      wr_strobe;
	uart_reg_e                 wr_addr;
	logic [`UART_DATA_W-1:0]   wr_data;
	logic                      rx_line;
	logic                      tx;
	logic                      tx_busy;
	logic                      rx_valid;
	logic [`UART_DATA_W-1:0]   rx_data;
	logic                      parity_err;
	logic                      frame_err;
	logic [`UART_ERRCNT_W-1:0] err_count;
	// Injected line model
	logic                      inject;
	logic                      drv_line;
	logic [`UART_ERRCNT_W-1:0] exp_errs;
	int                        rx_seen;
	int                        errors;
	int                        tests_pass;
	int                        tests_fail;
	int                        cycle_count;

	// Loopback unless the driver owns the line
	assign rx_line = inject ? drv_line : tx;

	uart_top DUT (
		.uart_clk  (uart_clk),
		.stop_bit  (stop_bit),
		.wr_strobe (wr_strobe),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rx        (rx_line),
		.tx        (tx),
		.tx_busy   (tx_busy),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data),
		.parity_err(parity_err),
		.frame_err (frame_err),
		.err_count (err_count)
	);

	bind uart_top uart_sva u_sva (
		.uart_clk (uart_clk),
		.stop_bit (stop_bit),
		.wr_strobe(wr_strobe),
		.wr_addr  (wr_addr),
		.tx       (tx),
		.tx_busy  (tx_busy),
		.rx_valid (rx_valid),
		.err_count(err_count)
	);

	always #50 uart_clk = ~uart_clk;

	// Count result strobes at mid cycle
	always @(negedge uart_clk) begin
		if (!stop_bit && rx_valid) rx_seen <= rx_seen + 1;
	end

	always @(posedge uart_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, tests did not complete", cycle_count);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic compare_byte(input string name, input logic [`UART_DATA_W-1:0] got,
		input logic [`UART_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_status(input logic exp_par, input logic exp_frm);
		compare_bit("parity_err", parity_err, exp_par);
		compare_bit("frame_err", frame_err, exp_frm);
	endtask

	task automatic compare_count(input string name, input logic [`UART_ERRCNT_W-1:0] got,
		input logic [`UART_ERRCNT_W-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("Error: %s", msg);
		errors++;
	endtask

	//////////////////////////////////////////////////
	// Bus, wait and line tasks
	//////////////////////////////////////////////////

	task automatic reg_write(input uart_reg_e addr, input logic [`UART_DATA_W-1:0] data);
		@(negedge uart_clk);
		wr_strobe = 1'b1;
		wr_addr   = addr;
		wr_data   = data;
		@(negedge uart_clk);
		wr_strobe = 1'b0;
	endtask

	// Divisor from the low byte with the high byte cleared
	task automatic set_line(input logic [`UART_DATA_W-1:0] div, input logic [7:0] cfg);
		reg_write(REG_DIV_LO, div);
		reg_write(REG_DIV_HI, 8'h00);
		reg_write(REG_CONFIG, cfg);
	endtask

	task automatic wait_rx(input int base, input int limit);
		int waited;
		waited = 0;
		while (rx_seen == base && waited < limit) begin
			@(negedge uart_clk);
			waited++;
		end
		if (rx_seen == base) begin
			report_failure($sformatf("rx_valid did not arrive within %0d cycles",
				limit));
		end
	endtask

	task automatic wait_idle(input int limit);
		int waited;
		waited = 0;
		while (tx_busy && waited < limit) begin
			@(negedge uart_clk);
			waited++;
		end
		if (tx_busy) report_failure("tx_busy stayed high past the frame end");
	endtask

	// Mid-bit sampling of tx, then high time of the stop region
	task automatic monitor_tx(input int bit_len, input bit par_en,
		output logic [7:0] data, output logic par, output int stop_len);
		int waited;
		data     = '0;
		par      = 1'b0;
		stop_len = 0;
		waited   = 0;
		@(negedge uart_clk);
		while (tx && waited < 4 * bit_len) begin
			@(negedge uart_clk);
			waited++;
		end
		if (tx) begin
			report_failure("tx never dropped for a start bit");
			return;
		end
		repeat (bit_len / 2) @(negedge uart_clk);
		compare_bit("tx start bit", tx, 1'b0);
		for (int i = 0; i < `UART_DATA_W; i++) begin
			repeat (bit_len) @(negedge uart_clk);
			data[i] = tx;
		end
		if (par_en) begin
			repeat (bit_len) @(negedge uart_clk);
			par = tx;
		end
		// First cycle of the first stop bit
		repeat (bit_len - bit_len / 2) @(negedge uart_clk);
		while (tx && tx_busy && stop_len < 4 * bit_len) begin
			stop_len++;
			@(negedge uart_clk);
		end
	endtask

	// Start, data LSB first, optional parity, one stop, one idle period
	task automatic drive_frame(input logic [7:0] data, input bit par_en, input logic par,
		input logic stop_level, input int bit_len);
		@(negedge uart_clk);
		drv_line = 1'b0;
		repeat (bit_len) @(negedge uart_clk);
		for (int i = 0; i < `UART_DATA_W; i++) begin
			drv_line = data[i];
			repeat (bit_len) @(negedge uart_clk);
		end
		if (par_en) begin
			drv_line = par;
			repeat (bit_len) @(negedge uart_clk);
		end
		drv_line = stop_level;
		repeat (bit_len) @(negedge uart_clk);
		drv_line = 1'b1;
		repeat (bit_len) @(negedge uart_clk);
	endtask

	task automatic finish_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			tests_pass++;
			$display("Test %s: pass", name);
		end else begin
			tests_fail++;
			$display("Test %s: fail, %0d errors", name, errors - start_errors);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_reset_loopback();
		int start_errors;
		int base;
		logic [7:0] b;
		start_errors = errors;
		compare_bit("tx", tx, 1'b1);
		compare_bit("tx_busy", tx_busy, 1'b0);
		compare_count("err_count", err_count, '0);
		for (int i = 0; i < 8; i++) begin
			b    = 8'($urandom_range(255, 0));
			base = rx_seen;
			reg_write(REG_TXDATA, b);
			wait_rx(base, 2 * 10 * DEF_BIT);
			compare_byte("rx_data", rx_data, b);
			compare_status(1'b0, 1'b0);
			wait_idle(2 * DEF_BIT);
		end
		finish_test("reset and default loopback", start_errors);
	endtask

	task automatic test_parity();
		int start_errors;
		int base;
		int stop_len;
		logic [7:0] b;
		logic [7:0] line_byte;
		logic line_par;
		start_errors = errors;
		// Even parity first, then odd
		for (int mode = 0; mode < 2; mode++) begin
			set_line(8'd7, (mode == 0) ? 8'h01 : 8'h02);
			b    = 8'($urandom_range(255, 0));
			base = rx_seen;
			reg_write(REG_TXDATA, b);
			monitor_tx(FAST_BIT, 1'b1, line_byte, line_par, stop_len);
			compare_byte("tx data", line_byte, b);
			compare_bit("tx parity", line_par, (mode == 0) ? ^b : ~^b);
			wait_rx(base, 2 * 11 * FAST_BIT);
			compare_byte("rx_data", rx_data, b);
			compare_status(1'b0, 1'b0);
		end
		finish_test("parity on line and loopback", start_errors);
	endtask

	task automatic test_two_stop();
		int start_errors;
		int base;
		int stop_len;
		logic [7:0] b;
		logic [7:0] line_byte;
		logic line_par;
		start_errors = errors;
		// Odd parity with two stop bits
		set_line(8'd7, 8'h06);
		b    = 8'($urandom_range(255, 0));
		base = rx_seen;
		reg_write(REG_TXDATA, b);
		monitor_tx(FAST_BIT, 1'b1, line_byte, line_par, stop_len);
		compare_byte("tx data", line_byte, b);
		compare_bit("tx parity", line_par, ~^b);
		if (stop_len < 2 * FAST_BIT) begin
			report_failure($sformatf("stop time of %0d cycles is under two bit periods",
				stop_len));
		end
		wait_rx(base, 2 * 12 * FAST_BIT);
		compare_byte("rx_data", rx_data, b);
		compare_status(1'b0, 1'b0);
		finish_test("two stop bits", start_errors);
	endtask

	task automatic test_parity_inject();
		int start_errors;
		int base;
		logic [7:0] b;
		start_errors = errors;
		set_line(8'd7, 8'h01);
		b        = 8'($urandom_range(255, 0));
		base     = rx_seen;
		inject   = 1'b1;
		// Even rule wants ^b so the opposite goes out
		drive_frame(b, 1'b1, ~^b, 1'b1, FAST_BIT);
		wait_rx(base, 2 * 12 * FAST_BIT);
		exp_errs = exp_errs + 1'b1;
		compare_byte("rx_data", rx_data, b);
		compare_status(1'b1, 1'b0);
		compare_count("err_count", err_count, exp_errs);
		inject = 1'b0;
		finish_test("injected parity error", start_errors);
	endtask

	task automatic test_framing_inject();
		int start_errors;
		int base;
		logic [7:0] b;
		start_errors = errors;
		b      = 8'($urandom_range(255, 0));
		base   = rx_seen;
		inject = 1'b1;
		drive_frame(b, 1'b1, ^b, 1'b0, FAST_BIT);
		wait_rx(base, 2 * 12 * FAST_BIT);
		exp_errs = exp_errs + 1'b1;
		compare_byte("rx_data", rx_data, b);
		compare_status(1'b0, 1'b1);
		compare_count("err_count", err_count, exp_errs);
		// Clean frame clears the flags and keeps the count
		b    = 8'($urandom_range(255, 0));
		base = rx_seen;
		drive_frame(b, 1'b1, ^b, 1'b1, FAST_BIT);
		wait_rx(base, 2 * 12 * FAST_BIT);
		compare_byte("rx_data", rx_data, b);
		compare_status(1'b0, 1'b0);
		compare_count("err_count", err_count, exp_errs);
		inject = 1'b0;
		finish_test("injected framing error", start_errors);
	endtask

	task automatic test_busy_write();
		int start_errors;
		int base;
		logic [7:0] first_b;
		logic [7:0] second_b;
		start_errors = errors;
		first_b  = 8'($urandom_range(255, 0));
		second_b = ~first_b;
		base     = rx_seen;
		reg_write(REG_TXDATA, first_b);
		compare_bit("tx_busy", tx_busy, 1'b1);
		reg_write(REG_TXDATA, second_b);
		wait_rx(base, 2 * 11 * FAST_BIT);
		compare_byte("rx_data", rx_data, first_b);
		wait_idle(2 * FAST_BIT);
		// Room for a second frame that must not come
		repeat (12 * FAST_BIT) @(negedge uart_clk);
		compare_bit("tx_busy", tx_busy, 1'b0);
		compare_count("rx_valid count", 8'(rx_seen - base), 8'd1);
		finish_test("write during busy", start_errors);
	endtask

	initial begin
		void'($urandom(41300));
		uart_clk    = 1'b0;
		stop_bit    = 1'b1;
		wr_strobe   = 1'b0;
		wr_addr     = REG_TXDATA;
		wr_data     = '0;
		inject      = 1'b0;
		drv_line    = 1'b1;
		exp_errs    = '0;
		rx_seen     = 0;
		errors      = 0;
		tests_pass  = 0;
		tests_fail  = 0;
		cycle_count = 0;
		repeat (3) @(posedge uart_clk);
		@(negedge uart_clk);
		stop_bit = 1'b0;
		@(negedge uart_clk);
		test_reset_loopback();
		test_parity();
		test_two_stop();
		test_parity_inject();
		test_framing_inject();
		test_busy_write();
		// Assertion failures from the bound checker
		errors = errors + DUT.u_sva.fail_count;
		$display("Tests passed: %0d, failed: %0d, checks failed: %0d",
			tests_pass, tests_fail, errors);
		if (errors == 0 && tests_fail == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- test/uart_sva.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_sva (
	input logic                      uart_clk,
	input logic                      stop_bit,
	input logic                      wr_strobe,
	input uart_pkg::uart_reg_e       wr_addr,
	input logic                      tx,
	input logic                      tx_busy,
	input logic                      rx_valid,
	input logic [`UART_ERRCNT_W-1:0] err_count
);
	import uart_pkg::*;

	// Assertion failures so far
	int fail_count = 0;

	//////////////////////////////////////////////////
	// Line and strobe rules
	//////////////////////////////////////////////////

	// Idle line is high
	tx_idle_high: assert property (@(posedge uart_clk) disable iff (stop_bit)
		!tx_busy |-> tx)
		else begin
			$error("tx low while encoder idle");
			fail_count++;
		end

	// Result strobe is one cycle wide
	rx_valid_single: assert property (@(posedge uart_clk) disable iff (stop_bit)
		rx_valid |=> !rx_valid)
		else begin
			$error("rx_valid high on two consecutive cycles");
			fail_count++;
		end

	// Counter only moves up outside reset
	errcnt_monotonic: assert property (@(posedge uart_clk) disable iff (stop_bit)
		!$past(stop_bit) |-> err_count >= $past(err_count))
		else begin
			$error("err_count decreased");
			fail_count++;
		end

	// Decode cycle, then encoder register, then start bit on the line
	tx_start_latency: assert property (@(posedge uart_clk) disable iff (stop_bit)
		wr_strobe && wr_addr == REG_TXDATA && !tx_busy |-> ##2 $fell(tx))
		else begin
			$error("tx did not fall two cycles after accepted write");
			fail_count++;
		end

endmodule

//--- verilog/uart_top.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_top (
	input  logic                      uart_clk,
	input  logic                      stop_bit,
	input  logic                      wr_strobe,
	input  uart_pkg::uart_reg_e       wr_addr,
	input  logic [`UART_DATA_W-1:0]   wr_data,
	input  logic                      rx,
	output logic                      tx,
	output logic                      tx_busy,
	output logic                      rx_valid,
	output logic [`UART_DATA_W-1:0]   rx_data,
	output logic                      parity_err,
	output logic                      frame_err,
	output logic [`UART_ERRCNT_W-1:0] err_count
);
	import uart_pkg::*;

	// Decode to execute
	logic                    tx_start;
	logic [`UART_DATA_W-1:0] tx_byte;
	logic [`UART_DIV_W-1:0]  divisor;
	uart_parity_e            parity;
	logic                    two_stop;
	// Execute to result
	logic                    frame_done;
	logic [`UART_DATA_W-1:0] frame_byte;
	logic                    frame_parity_err;
	logic                    frame_stop_err;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	uart_cmd_decode u_cmd_decode (
		.uart_clk (uart_clk),
		.stop_bit (stop_bit),
		.wr_strobe(wr_strobe),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.divisor  (divisor),
		.parity   (parity),
		.two_stop (two_stop)
	);

	//////////////////////////////////////////////////
	// Execute, transmit and receive paths
	//////////////////////////////////////////////////

	uart_encoder u_encoder (
		.uart_clk(uart_clk),
		.stop_bit(stop_bit),
		.tx_start(tx_start),
		.tx_byte (tx_byte),
		.divisor (divisor),
		.parity  (parity),
		.two_stop(two_stop),
		.tx      (tx),
		.tx_busy (tx_busy)
	);

	// Same line settings as the encoder
	uart_decoder u_decoder (
		.uart_clk        (uart_clk),
		.stop_bit        (stop_bit),
		.rx              (rx),
		.divisor         (divisor),
		.parity          (parity),
		.two_stop        (two_stop),
		.frame_done      (frame_done),
		.frame_byte      (frame_byte),
		.frame_parity_err(frame_parity_err),
		.frame_stop_err  (frame_stop_err)
	);

	//////////////////////////////////////////////////
	// Result
	//////////////////////////////////////////////////

	uart_result u_result (
		.uart_clk        (uart_clk),
		.stop_bit        (stop_bit),
		.frame_done      (frame_done),
		.frame_byte      (frame_byte),
		.frame_parity_err(frame_parity_err),
		.frame_stop_err  (frame_stop_err),
		.rx_valid        (rx_valid),
		.rx_data         (rx_data),
		.parity_err      (parity_err),
		.frame_err       (frame_err),
		.err_count       (err_count)
	);

endmodule

//--- verilog/uart_result.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_result (
	input  logic                      uart_clk,
	input  logic                      stop_bit,
	input  logic                      frame_done,
	input  logic [`UART_DATA_W-1:0]   frame_byte,
	input  logic                      frame_parity_err,
	input  logic                      frame_stop_err,
	output logic                      rx_valid,
	output logic [`UART_DATA_W-1:0]   rx_data,
	output logic                      parity_err,
	output logic                      frame_err,
	output logic [`UART_ERRCNT_W-1:0] err_count
);

	logic frame_bad;

	// Either check failing marks the frame bad
	assign frame_bad = frame_parity_err | frame_stop_err;

	//////////////////////////////////////////////////
	// Strobe, status flags and error counter
	//////////////////////////////////////////////////

	always_ff @(posedge uart_clk or posedge stop_bit) begin
		if (stop_bit) begin
			rx_valid   <= 1'b0;
			parity_err <= 1'b0;
			frame_err  <= 1'b0;
			err_count  <= '0;
		end else begin
			// One cycle behind frame_done
			rx_valid <= frame_done;
			if (frame_done) begin
				parity_err <= frame_parity_err;
				frame_err  <= frame_stop_err;
				// Sticks at all ones
				if (frame_bad && err_count != '1) begin
					err_count <= err_count + 1'b1;
				end
			end
		end
	end

	// Received byte, overwritten by each new frame
	always_ff @(posedge uart_clk) begin
		if (frame_done) begin
			rx_data <= frame_byte;
		end
	end

endmodule

//--- verilog/uart_decoder.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_decoder (
	input  logic                    uart_clk,
	input  logic                    stop_bit,
	input  logic                    rx,
	input  logic [`UART_DIV_W-1:0]  divisor,
	input  uart_pkg::uart_parity_e  parity,
	input  logic                    two_stop,
	output logic                    frame_done,
	output logic [`UART_DATA_W-1:0] frame_byte,
	output logic                    frame_parity_err,
	output logic                    frame_stop_err
);
	import uart_pkg::*;

	localparam int IDX_W = $clog2(`UART_DATA_W);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`UART_DATA_W - 1);

	uart_rx_state_e         state;
	logic                   rx_meta;
	logic                   rx_sync;
	logic [`UART_DIV_W-1:0] bit_cnt;
	logic [IDX_W-1:0]       bit_idx;
	logic                   stop_seen;
	logic                   skip_stop;
	logic                   bit_end;
	logic                   half_end;
	logic                   cnt_wrap;
	// Config captured at the falling edge of the start bit
	logic [`UART_DIV_W-1:0] div_q;
	uart_parity_e           par_q;
	logic                   two_stop_q;

	assign bit_end  = (bit_cnt == div_q);
	assign half_end = (bit_cnt == (div_q >> 1));
	// Start bit qualified at half period, later bits one period apart
	assign cnt_wrap = (state == RX_START) ? half_end : bit_end;

	always_ff @(posedge uart_clk) begin
		if (state == RX_IDLE && !rx_sync) begin
			div_q      <= divisor;
			par_q      <= parity;
			two_stop_q <= two_stop;
		end
	end

	always_ff @(posedge uart_clk or posedge stop_bit) begin
		if (stop_bit) begin
			bit_cnt <= '0;
		end else if (state == RX_IDLE || cnt_wrap) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Synchronizer and frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge uart_clk or posedge stop_bit) begin
		if (stop_bit) begin
			rx_meta    <= 1'b1;
			rx_sync    <= 1'b1;
			state      <= RX_IDLE;
			bit_idx    <= '0;
			stop_seen  <= 1'b0;
			skip_stop  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			rx_meta    <= rx;
			rx_sync    <= rx_meta;
			frame_done <= 1'b0;
			case (state)
				RX_IDLE: if (!rx_sync) state <= RX_START;
				RX_START: begin
					// Short low pulse is dropped as noise
					if (half_end) begin
						bit_idx <= '0;
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						if (bit_idx == LAST_IDX) begin
							state <= parity_on(par_q) ? RX_PARITY : RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				RX_PARITY: if (bit_end) state <= RX_STOP;
				RX_STOP: begin
					if (!stop_seen) begin
						// First stop bit sampled, frame reported here
						if (bit_end) begin
							stop_seen  <= 1'b1;
							skip_stop  <= two_stop_q;
							frame_done <= 1'b1;
						end
					end else if (skip_stop) begin
						// Second stop bit is passed over unchecked
						if (bit_end) skip_stop <= 1'b0;
					end else if (rx_sync) begin
						// Line back high before rearming
						stop_seen <= 1'b0;
						state     <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data and status captured at the sample points
	always_ff @(posedge uart_clk) begin
		if (state == RX_START && half_end) frame_parity_err <= 1'b0;
		if (state == RX_DATA && bit_end) frame_byte[bit_idx] <= rx_sync;
		if (state == RX_PARITY && bit_end) begin
			frame_parity_err <= rx_sync ^ parity_bit(frame_byte, par_q);
		end
		if (state == RX_STOP && !stop_seen && bit_end) frame_stop_err <= ~rx_sync;
	end

endmodule

//--- verilog/uart_encoder.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_encoder (
	input  logic                    uart_clk,
	input  logic                    stop_bit,
	input  logic                    tx_start,
	input  logic [`UART_DATA_W-1:0] tx_byte,
	input  logic [`UART_DIV_W-1:0]  divisor,
	input  uart_pkg::uart_parity_e  parity,
	input  logic                    two_stop,
	output logic                    tx,
	output logic                    tx_busy
);
	import uart_pkg::*;

	localparam int IDX_W = $clog2(`UART_DATA_W);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`UART_DATA_W - 1);

	uart_tx_state_e          state;
	logic [`UART_DIV_W-1:0]  bit_cnt;
	logic [IDX_W-1:0]        bit_idx;
	logic                    stop_idx;
	logic                    bit_end;
	// Frame settings, frozen for the whole frame
	logic [`UART_DATA_W-1:0] byte_q;
	logic [`UART_DIV_W-1:0]  div_q;
	uart_parity_e            par_q;
	logic                    two_stop_q;

	assign bit_end = (bit_cnt == div_q);
	// High from the start pulse through the last stop bit
	assign tx_busy = tx_start | (state != TX_IDLE);

	// Latch frame settings on start
	always_ff @(posedge uart_clk) begin
		if (state == TX_IDLE && tx_start) begin
			byte_q     <= tx_byte;
			div_q      <= divisor;
			par_q      <= parity;
			two_stop_q <= two_stop;
		end
	end

	// Bit period counter, divisor+1 clocks per bit
	always_ff @(posedge uart_clk or posedge stop_bit) begin
		if (stop_bit) begin
			bit_cnt <= '0;
		end else if (state == TX_IDLE || bit_end) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Frame FSM, line driven from a register
	//////////////////////////////////////////////////

	always_ff @(posedge uart_clk or posedge stop_bit) begin
		if (stop_bit) begin
			state    <= TX_IDLE;
			bit_idx  <= '0;
			stop_idx <= 1'b0;
			tx       <= 1'b1;
		end else if (state == TX_IDLE) begin
			if (tx_start) begin
				state <= TX_START;
				tx    <= 1'b0;
			end
		end else if (bit_end) begin
			case (state)
				TX_START: begin
					state   <= TX_DATA;
					bit_idx <= '0;
					tx      <= byte_q[0];
				end
				TX_DATA: begin
					if (bit_idx == LAST_IDX) begin
						if (parity_on(par_q)) begin
							state <= TX_PARITY;
							tx    <= parity_bit(byte_q, par_q);
						end else begin
							state    <= TX_STOP;
							stop_idx <= 1'b0;
							tx       <= 1'b1;
						end
					end else begin
						// LSB first
						bit_idx <= bit_idx + 1'b1;
						tx      <= byte_q[bit_idx + 1'b1];
					end
				end
				TX_PARITY: begin
					state    <= TX_STOP;
					stop_idx <= 1'b0;
					tx       <= 1'b1;
				end
				TX_STOP: begin
					// Second stop bit only when selected
					if (two_stop_q && !stop_idx) begin
						stop_idx <= 1'b1;
					end else begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/uart_cmd_decode.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_cmd_decode (
	input  logic                    uart_clk,
	input  logic                    stop_bit,
	input  logic                    wr_strobe,
	input  uart_pkg::uart_reg_e     wr_addr,
	input  logic [`UART_DATA_W-1:0] wr_data,
	input  logic                    tx_busy,
	output logic                    tx_start,
	output logic [`UART_DATA_W-1:0] tx_byte,
	output logic [`UART_DIV_W-1:0]  divisor,
	output uart_pkg::uart_parity_e  parity,
	output logic                    two_stop
);
	import uart_pkg::*;

	// 16 clocks per bit out of reset
	localparam logic [`UART_DIV_W-1:0] DIV_RESET = `UART_DIV_W'(15);

	logic tx_accept;

	// Transmit write only taken while encoder is idle
	assign tx_accept = wr_strobe && (wr_addr == REG_TXDATA) && !tx_busy;

	//////////////////////////////////////////////////
	// Configuration registers
	//////////////////////////////////////////////////

	always_ff @(posedge uart_clk or posedge stop_bit) begin
		if (stop_bit) begin
			tx_start <= 1'b0;
			divisor  <= DIV_RESET;
			parity   <= PARITY_NONE;
			two_stop <= 1'b0;
		end else begin
			// One-cycle start pulse toward encoder
			tx_start <= tx_accept;
			if (wr_strobe) begin
				case (wr_addr)
					REG_CONFIG: begin
						// Bits 1:0 parity code, bit 2 stop select
						parity   <= uart_parity_e'(wr_data[1:0]);
						two_stop <= wr_data[2];
					end
					REG_DIV_LO: divisor[`UART_DATA_W-1:0] <= wr_data;
					REG_DIV_HI: divisor[`UART_DIV_W-1:`UART_DATA_W] <= wr_data;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Transmit data holding register
	//////////////////////////////////////////////////

	// Held until the next accepted write
	always_ff @(posedge uart_clk) begin
		if (tx_accept) begin
			tx_byte <= wr_data;
		end
	end

endmodule

//--- verilog/uart_pkg.sv
`include "uart_defs.svh"

package uart_pkg;

	// Write port opcodes
	typedef enum logic [`UART_ADDR_W-1:0] {
		REG_TXDATA = 2'd0,
		REG_CONFIG = 2'd1,
		REG_DIV_LO = 2'd2,
		REG_DIV_HI = 2'd3
	} uart_reg_e;

	// Code 3 is left out and behaves as no parity
	typedef enum logic [1:0] {
		PARITY_NONE = 2'd0,
		PARITY_EVEN = 2'd1,
		PARITY_ODD  = 2'd2
	} uart_parity_e;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} uart_tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} uart_rx_state_e;

	// Parity slot present on the line
	function automatic logic parity_on(uart_parity_e mode);
		return (mode == PARITY_EVEN) || (mode == PARITY_ODD);
	endfunction

	// Even: data XOR bit is 0, odd: data XOR bit is 1
	function automatic logic parity_bit(logic [`UART_DATA_W-1:0] data, uart_parity_e mode);
		return (mode == PARITY_ODD) ? ~^data : ^data;
	endfunction

endpackage

//--- include/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

//////////////////////////////////////////////////
// Register map widths
//////////////////////////////////////////////////

// Data byte carried on the line and in the registers
`define UART_DATA_W 8

// Baud divisor, one bit period is divisor+1 clocks
`define UART_DIV_W 16

// Register select field
`define UART_ADDR_W 2

//////////////////////////////////////////////////
// Status widths
//////////////////////////////////////////////////

// Erroneous frame counter, saturates at all ones
`define UART_ERRCNT_W 8

`endif
